// ==== html_attr_decoder.sv ====
`timescale 1ns/1ps

module html_attr_decoder (
	input logic clock,
	input logic rst,
	input logic tok_valid,
	input logic tok_ready,
	input html_char_pkg::lex_tok_t tok,
	output html_render_pkg::attr_set_t attrs
);
	import html_char_pkg::*;
	import html_render_pkg::*;

	typedef enum logic [2:0] {
		NAME_NONE,
		NAME_COLOR,
		NAME_SIZE,
		NAME_BG,
		NAME_OTHER
	} name_t;

	name_t name;
	logic after_eq;
	logic tok_take;
	logic is_digit;

	function automatic name_t name_of(input char_t c);
		case (c)
			"c": return NAME_COLOR;
			"s": return NAME_SIZE;
			"b": return NAME_BG;
			default: return NAME_OTHER;
		endcase
	endfunction

	assign tok_take = tok_valid && tok_ready;
	assign is_digit = (tok.ch >= "0") && (tok.ch <= "9");

	always_ff @(posedge clock) begin
		if (rst || (tok_take && tok.kind == TOK_TAG_END)) begin
			name <= NAME_NONE; // Ctrl has sampled attrs on this edge.
			after_eq <= 1'b0;
			attrs.color <= default_color;
			attrs.size <= default_size;
			attrs.background <= default_color;
		end else if (tok_take && tok.kind == TOK_ATTR) begin
			if (tok.ch == " ") begin
				name <= NAME_NONE;
				after_eq <= 1'b0;
			end else if (tok.ch == "=") begin
				after_eq <= 1'b1;
			end else if (after_eq) begin
				after_eq <= 1'b0; // Single digit values only.
				if (is_digit) begin
					// ASCII digits carry their value in the low bits.
					case (name)
						NAME_COLOR: attrs.color <= tok.ch[2:0];
						NAME_SIZE: attrs.size <= tok.ch[1:0];
						NAME_BG: attrs.background <= tok.ch[2:0];
						default: ;
					endcase
				end
			end else if (name == NAME_NONE) begin
				name <= name_of(tok.ch);
			end
		end
	end

endmodule

// ==== html_char_pkg.sv ====
package html_char_pkg;

	typedef logic [7:0] char_t;

	localparam int page_len = 109; // Bytes of the built-in page.
	localparam int page_addr_w = $clog2(page_len);

	typedef logic [page_addr_w-1:0] page_addr_t;

	typedef enum logic [1:0] {
		TAG_BODY,
		TAG_P,
		TAG_OTHER
	} tag_id_t;

	typedef enum logic [1:0] {
		TOK_TEXT,
		TOK_ATTR, // Tag byte after the name.
		TOK_TAG_END
	} tok_kind_t;

	typedef struct packed {
		tok_kind_t kind;
		char_t ch;
		tag_id_t tag;
		logic closing;
	} lex_tok_t;

endpackage

// ==== html_char_source.sv ====
`timescale 1ns/1ps

module html_char_source (
	input logic clock,
	input logic rst,
	input logic start,
	input logic char_ready,
	output logic char_valid,
	output html_char_pkg::char_t char
);
	import html_char_pkg::*;

	page_addr_t addr;

	// Fixed page text with the first byte in the top bits.
	function automatic char_t page_char(input page_addr_t a);
		logic [8*page_len-1:0] text;
		text = {
			"<body background=7>",
			"<p color=0 size=2 >",
			"THANKS</p>",
			"<p color=2>",
			"BEST TA</p>",
			"<p color=3 size=1 >",
			"SR and JC</p>",
			"</body>"
		};
		return text[8*(page_len-1-int'(a)) +: 8];
	endfunction

	assign char = page_char(addr);

	always_ff @(posedge clock) begin
		if (rst) begin
			char_valid <= 1'b0;
			addr <= '0;
		end else if (!char_valid) begin
			if (start) begin
				char_valid <= 1'b1; // First byte offered next cycle.
				addr <= '0;
			end
		end else if (char_ready) begin
			if (addr == page_addr_t'(page_len - 1)) begin
				char_valid <= 1'b0; // Idle after the last byte.
			end else begin
				addr <= addr + 1'b1;
			end
		end
	end

endmodule

// ==== html_parse_ctrl.sv ====
`timescale 1ns/1ps

module html_parse_ctrl (
	input logic clock,
	input logic rst,
	input logic start,
	output logic busy,
	input logic tok_valid,
	input html_char_pkg::lex_tok_t tok,
	output logic tok_ready,
	input html_render_pkg::attr_set_t attrs,
	output logic cmd_valid,
	output html_render_pkg::render_cmd_t cmd,
	input logic cmd_ready
);
	import html_char_pkg::*;
	import html_render_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_OUTSIDE,
		S_IN_PARA,
		S_FINISH
	} state_t;

	state_t state;
	state_t state_next;
	logic running;
	logic tok_take;
	logic cmd_take;
	logic emit;
	render_cmd_t cmd_next;
	color_t para_color;
	size_t para_size;

	assign running = (state == S_OUTSIDE) || (state == S_IN_PARA);
	assign busy = (state != S_IDLE);
	assign cmd_take = cmd_valid && cmd_ready;
	assign tok_ready = running && (!cmd_valid || cmd_ready); // Stall on a held command.
	assign tok_take = tok_valid && tok_ready;

	always_comb begin
		state_next = state;
		emit = 1'b0;
		cmd_next.op = OP_CHAR;
		cmd_next.color = para_color;
		cmd_next.size = para_size;
		cmd_next.ch = tok.ch;
		case (state)
			S_IDLE: begin
				if (start)
					state_next = S_OUTSIDE;
			end
			S_FINISH: begin
				if (cmd_take)
					state_next = S_IDLE; // Done has left.
			end
			default: begin
				if (tok_take && tok.kind == TOK_TEXT) begin
					emit = (state == S_IN_PARA); // Stray text is dropped.
				end else if (tok_take && tok.kind == TOK_TAG_END) begin
					cmd_next.ch = '0;
					case (tok.tag)
						TAG_BODY: begin
							emit = 1'b1;
							cmd_next.size = default_size;
							if (tok.closing) begin
								cmd_next.op = OP_DONE;
								cmd_next.color = default_color;
								state_next = S_FINISH;
							end else begin
								cmd_next.op = OP_BACKGROUND;
								cmd_next.color = attrs.background;
								state_next = S_OUTSIDE;
							end
						end
						TAG_P: begin
							if (tok.closing) begin
								emit = (state == S_IN_PARA);
								cmd_next.op = OP_PARA_END;
								state_next = S_OUTSIDE;
							end else begin
								emit = 1'b1;
								cmd_next.op = OP_PARA_BEGIN;
								cmd_next.color = attrs.color;
								cmd_next.size = attrs.size;
								state_next = S_IN_PARA;
							end
						end
						default: ;
					endcase
				end
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= S_IDLE;
			cmd_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (cmd_take)
				cmd_valid <= 1'b0;
			if (emit)
				cmd_valid <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (emit)
			cmd <= cmd_next;
		if (emit && cmd_next.op == OP_PARA_BEGIN) begin
			para_color <= cmd_next.color; // Characters inherit these.
			para_size <= cmd_next.size;
		end
	end

endmodule

// ==== html_render_assert.sv ====
`timescale 1ns/1ps

module html_render_assert (
	input logic clock,
	input logic rst,
	input logic cmd_valid,
	input logic cmd_ready,
	input html_render_pkg::render_cmd_t cmd,
	input logic char_valid,
	input logic char_ready,
	input html_char_pkg::char_t char,
	input logic busy
);

	cmd_hold: assert property (@(posedge clock) disable iff (rst)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
		else $error("command changed while stalled");

	char_hold: assert property (@(posedge clock) disable iff (rst)
		char_valid && !char_ready |=> char_valid && $stable(char))
		else $error("character changed while stalled");

	// Sync reset, so outputs are clear one edge later.
	reset_quiet: assert property (@(posedge clock)
		rst |=> !cmd_valid && !char_valid && !busy)
		else $error("valid or busy high during reset");

endmodule

// ==== html_render_pkg.sv ====
package html_render_pkg;

	typedef logic [2:0] color_t;
	typedef logic [1:0] size_t;

	typedef enum logic [2:0] {
		OP_BACKGROUND,
		OP_PARA_BEGIN,
		OP_CHAR,
		OP_PARA_END,
		OP_DONE
	} render_op_t;

	typedef struct packed {
		color_t color;
		size_t size;
		color_t background;
	} attr_set_t;

	// One render command, 16 bits.
	typedef struct packed {
		render_op_t op;
		color_t color;
		size_t size;
		html_char_pkg::char_t ch;
	} render_cmd_t;

	localparam color_t default_color = 3'd0;
	localparam size_t default_size = 2'd1;

endpackage

// ==== html_render_top.sv ====
`timescale 1ns/1ps

module html_render_top (
	input logic clock,
	input logic rst,
	input logic start,
	output logic busy,
	output logic cmd_valid,
	output html_render_pkg::render_cmd_t cmd,
	input logic cmd_ready
);
	import html_char_pkg::*;
	import html_render_pkg::*;

	logic char_valid;
	logic char_ready;
	char_t char;
	logic tok_valid;
	logic tok_ready;
	lex_tok_t tok;
	attr_set_t attrs;

	html_char_source u_source (
		.clock(clock),
		.rst(rst),
		.start(start && !busy), // Replays only from idle.
		.char_ready(char_ready),
		.char_valid(char_valid),
		.char(char)
	);

	html_tag_lexer u_lexer (
		.clock(clock),
		.rst(rst),
		.char_valid(char_valid),
		.char(char),
		.char_ready(char_ready),
		.tok_valid(tok_valid),
		.tok(tok),
		.tok_ready(tok_ready)
	);

	html_attr_decoder u_attr (
		.clock(clock),
		.rst(rst),
		.tok_valid(tok_valid),
		.tok_ready(tok_ready),
		.tok(tok),
		.attrs(attrs)
	);

	html_parse_ctrl u_ctrl (
		.clock(clock),
		.rst(rst),
		.start(start),
		.busy(busy),
		.tok_valid(tok_valid),
		.tok(tok),
		.tok_ready(tok_ready),
		.attrs(attrs),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_ready(cmd_ready)
	);

endmodule

// ==== html_tag_lexer.sv ====
`timescale 1ns/1ps

module html_tag_lexer (
	input logic clock,
	input logic rst,
	input logic char_valid,
	input html_char_pkg::char_t char,
	output logic char_ready,
	output logic tok_valid,
	output html_char_pkg::lex_tok_t tok,
	input logic tok_ready
);
	import html_char_pkg::*;

	typedef enum logic [1:0] {
		S_TEXT,
		S_TAG_OPEN,
		S_TAG_NAME,
		S_TAG_BODY
	} state_t;

	state_t state;
	logic closing_r;
	logic body_hit;
	logic p_hit;
	logic [2:0] name_len;
	logic char_take;
	logic name_char;
	logic emit;
	tag_id_t tag_now;
	lex_tok_t tok_next;

	function automatic char_t body_char(input logic [2:0] idx);
		case (idx)
			3'd0: return "b";
			3'd1: return "o";
			3'd2: return "d";
			3'd3: return "y";
			default: return 8'h00;
		endcase
	endfunction

	assign char_ready = !tok_valid || tok_ready;
	assign char_take = char_valid && char_ready;
	assign name_char = (state == S_TAG_OPEN || state == S_TAG_NAME) &&
		char != ">" && char != " " && !(state == S_TAG_OPEN && char == "/");

	always_comb begin
		if (p_hit && name_len == 3'd1)
			tag_now = TAG_P;
		else if (body_hit && name_len == 3'd4)
			tag_now = TAG_BODY;
		else
			tag_now = TAG_OTHER;
	end

	always_comb begin
		emit = 1'b0;
		tok_next.kind = TOK_TEXT;
		tok_next.ch = char;
		tok_next.tag = tag_now;
		tok_next.closing = closing_r;
		case (state)
			S_TEXT: begin
				emit = (char != "<");
			end
			S_TAG_OPEN, S_TAG_NAME: begin
				if (char == ">") begin
					emit = 1'b1;
					tok_next.kind = TOK_TAG_END;
				end else if (char == " " && state == S_TAG_NAME) begin
					emit = 1'b1; // Separator goes to the decoder.
					tok_next.kind = TOK_ATTR;
				end
			end
			default: begin
				emit = 1'b1;
				tok_next.kind = (char == ">") ? TOK_TAG_END : TOK_ATTR;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= S_TEXT;
			tok_valid <= 1'b0;
		end else begin
			if (tok_valid && tok_ready)
				tok_valid <= 1'b0;
			if (char_take) begin
				if (emit)
					tok_valid <= 1'b1;
				case (state)
					S_TEXT: begin
						if (char == "<")
							state <= S_TAG_OPEN;
					end
					S_TAG_OPEN, S_TAG_NAME: begin
						if (char == ">")
							state <= S_TEXT;
						else if (char == " " && state == S_TAG_NAME)
							state <= S_TAG_BODY;
						else if (name_char)
							state <= S_TAG_NAME;
					end
					default: begin
						if (char == ">")
							state <= S_TEXT;
					end
				endcase
			end
		end
	end

	// Token payload and the running name match.
	always_ff @(posedge clock) begin
		if (char_take) begin
			if (emit)
				tok <= tok_next;
			if (state == S_TEXT && char == "<") begin
				closing_r <= 1'b0;
				body_hit <= 1'b1;
				p_hit <= 1'b1;
				name_len <= 3'd0;
			end else if (name_char) begin
				body_hit <= body_hit && (char == body_char(name_len));
				p_hit <= p_hit && name_len == 3'd0 && char == "p";
				if (name_len != 3'd7)
					name_len <= name_len + 3'd1; // Saturates on long names.
			end else if (state == S_TAG_OPEN && char == "/") begin
				closing_r <= 1'b1;
			end
		end
	end

endmodule

// ==== list.f ====
html_char_pkg.sv
html_render_pkg.sv
html_char_source.sv
html_tag_lexer.sv
html_attr_decoder.sv
html_parse_ctrl.sv
html_render_top.sv
html_render_assert.sv
tb_html_render.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_html_render -f list.f > build.log 2>&1 &&
./obj_dir/Vtb_html_render > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1
exit 0

// ==== tb_html_render.sv ====
`timescale 1ns/1ps

module tb_html_render;
	import html_render_pkg::*;

	typedef struct packed {
		logic random_ready;
		logic mid_start;
	} run_cfg_t;

	localparam int num_runs = 4;
	localparam int wait_limit = 500;
	localparam int quiet_cycles = 20;
	localparam int mid_start_at = 10;

	logic clock = 1'b0;
	logic rst = 1'b1;
	logic start = 1'b0;
	logic cmd_ready = 1'b0;
	logic busy;
	logic cmd_valid;
	render_cmd_t cmd;

	// Ready mode and start-while-busy per run.
	run_cfg_t runs [num_runs] = '{'{1'b0, 1'b0}, '{1'b1, 1'b0}, '{1'b0, 1'b1}, '{1'b1, 1'b1}};
	render_cmd_t expected [$];
	int start_reqs = 0;
	int start_sent = 0;
	logic random_mode = 1'b0;
	int checks = 0;
	int errors = 0;
	logic aborted = 1'b0;

	html_render_top uut (
		.clock(clock),
		.rst(rst),
		.start(start),
		.busy(busy),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_ready(cmd_ready)
	);

	bind html_render_top html_render_assert u_assert (
		.clock(clock),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd(cmd),
		.char_valid(char_valid),
		.char_ready(char_ready),
		.char(char),
		.busy(busy)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		start <= (start_reqs != start_sent); // One cycle per request.
		start_sent <= start_reqs;
		if (random_mode)
			cmd_ready <= ($urandom % 3) != 0;
		else
			cmd_ready <= 1'b1;
	end

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic push_cmd(input render_op_t op, input int color, input int size, input byte ch);
		render_cmd_t c;
		c.op = op;
		c.color = color_t'(color);
		c.size = size_t'(size);
		c.ch = ch;
		expected.push_back(c);
	endtask

	// Paragraph attributes ride along on every command inside it.
	task automatic push_para(input int color, input int size, input string text);
		push_cmd(OP_PARA_BEGIN, color, size, 8'h00);
		for (int i = 0; i < text.len(); i++)
			push_cmd(OP_CHAR, color, size, text[i]);
		push_cmd(OP_PARA_END, color, size, 8'h00);
	endtask

	task automatic build_table();
		expected.delete();
		push_cmd(OP_BACKGROUND, 7, 1, 8'h00);
		push_para(0, 2, "THANKS");
		push_para(2, 1, "BEST TA"); // No size given.
		push_para(3, 1, "SR and JC");
		push_cmd(OP_DONE, 0, 1, 8'h00);
	endtask

	task automatic wait_cmd(output render_cmd_t got, output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		got = '0;
		while (!ok && n < wait_limit) begin
			@(negedge clock);
			if (cmd_valid && cmd_ready) begin
				got = cmd; // Transfers on the next edge.
				ok = 1'b1;
			end
			n++;
		end
	endtask

	task automatic wait_idle(output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < wait_limit) begin
			@(negedge clock);
			ok = !busy;
			n++;
		end
	endtask

	task automatic check_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			check_value("cmd_valid", int'(cmd_valid), 0);
			check_value("busy", int'(busy), 0);
		end
	endtask

	task automatic play_run(input run_cfg_t cfg);
		render_cmd_t got;
		logic ok;
		int idx;
		random_mode = cfg.random_ready;
		start_reqs++;
		idx = 0;
		ok = 1'b1;
		while (ok && idx < expected.size()) begin
			wait_cmd(got, ok);
			if (!ok) begin
				errors++;
				aborted = 1'b1;
				$display("Timeout at %0t waiting for command %0d", $time, idx);
			end else begin
				check_value("cmd.op", int'(got.op), int'(expected[idx].op));
				check_value("cmd.color", int'(got.color), int'(expected[idx].color));
				check_value("cmd.size", int'(got.size), int'(expected[idx].size));
				check_value("cmd.ch", int'(got.ch), int'(expected[idx].ch));
				check_value("busy", int'(busy), 1); // Held until done leaves.
				if (cfg.mid_start && idx == mid_start_at)
					start_reqs++; // Lands while busy.
				idx++;
			end
		end
		if (ok) begin
			wait_idle(ok);
			if (!ok) begin
				errors++;
				aborted = 1'b1;
				$display("Timeout at %0t waiting for busy to fall", $time);
			end else begin
				check_quiet(quiet_cycles);
			end
		end
	endtask

	initial begin
		int err_mark;
		int tests_done;
		void'($urandom(29));
		build_table();
		repeat (4) @(posedge clock);
		rst <= 1'b0;
		err_mark = errors;
		check_quiet(quiet_cycles);
		$display("Test 0 idle after reset: %s", (errors == err_mark) ? "ok" : "failed");
		tests_done = 1;
		for (int t = 0; t < num_runs && !aborted; t++) begin
			err_mark = errors;
			play_run(runs[t]);
			$display("Test %0d page run, random ready %0d, start while busy %0d: %s",
				t + 1, runs[t].random_ready, runs[t].mid_start,
				(errors == err_mark) ? "ok" : "failed");
			tests_done++;
		end
		$display("Tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
